/* verilog/axi_bus_pkg.sv */
// AXI bus sizes
// Widths and burst limits of the write bus

package axi_bus_pkg;

  // Address and data widths
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // Bytes per beat and its log2
  localparam int strb_w = data_w / 8;
  localparam int log_strb_w = $clog2(strb_w);

  // Longest burst, bounded by the 4 KB rule and the 256 beat limit
  localparam int burst_beats = (4096 / strb_w < 256) ? 4096 / strb_w : 256;

  // Bytes covered by one full burst
  localparam int burst_bytes = strb_w * burst_beats;

  // Low address bits cleared to align on a burst boundary
  localparam logic [addr_w-1:0] burst_mask = addr_w'(burst_bytes - 1);

  // AWLEN field width
  localparam int len_w = 8;

endpackage : axi_bus_pkg

/* verilog/write_master_pkg.sv */
// Write master sizes
// Command, counter and buffer dimensions

package write_master_pkg;

  import axi_bus_pkg::*;

  // Byte count of one command
  localparam int xfer_size_w = 16;

  // Beat count, byte count over the beat size
  localparam int total_len_w = xfer_size_w - log_strb_w;

  // Burst index, the beat count above the AWLEN field
  localparam int xact_cnt_w = total_len_w - len_w;

  // Bursts allowed to wait for a write response
  localparam int max_outstanding = 4;
  localparam int outstanding_w = $clog2(max_outstanding + 1);

  // Stream side data buffer
  localparam int fifo_depth = 32;
  localparam int fifo_ptr_w = $clog2(fifo_depth);

  // First beats still waiting for their address
  localparam int pending_w = 8;

endpackage : write_master_pkg

/* verilog/xfer_ctrl.sv */
// Transfer control
`timescale 1ns/1ps

module xfer_ctrl
  import axi_bus_pkg::*;
  import write_master_pkg::*;
(
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   ctrl_start,
  input  logic [addr_w-1:0]      ctrl_addr_offset,
  input  logic [xfer_size_w-1:0] ctrl_xfer_size_in_bytes,
  input  logic                   final_bxfer,
  output logic                   start,
  output logic [xact_cnt_w-1:0]  num_xacts,
  output logic [len_w-1:0]       final_burst_len,
  output logic                   single_xact,
  output logic [strb_w-1:0]      final_strb,
  output logic [addr_w-1:0]      addr_base,
  output logic                   ctrl_done
);

  logic [total_len_w-1:0] total_len_r;
  logic [log_strb_w-1:0]  byte_rem_r;
  logic                   cmd_seen;
  logic                   start_d1;

  ////////////////////////////////////////////////////////////
  // Command capture
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Beats minus one, a partial last word counts as a whole beat
      if (ctrl_xfer_size_in_bytes[log_strb_w-1:0] != '0)
        total_len_r <= ctrl_xfer_size_in_bytes[log_strb_w +: total_len_w];
      else
        total_len_r <= ctrl_xfer_size_in_bytes[log_strb_w +: total_len_w] - 1'b1;
      // Start on a burst boundary
      addr_base  <= ctrl_addr_offset & ~burst_mask;
      byte_rem_r <= ctrl_xfer_size_in_bytes[log_strb_w-1:0];
    end
  end

  // Bursts minus one sit above the AWLEN bits
  assign num_xacts   = total_len_r[len_w +: xact_cnt_w];
  assign single_xact = (num_xacts == '0);

  // Last burst length and byte enable, settled before start
  always_ff @(posedge aclk) begin
    final_burst_len <= total_len_r[len_w-1:0];
    for (int i = 0; i < strb_w; i++) begin
      final_strb[i] <= (byte_rem_r == '0) || (i < int'(byte_rem_r));
    end
  end

  ////////////////////////////////////////////////////////////
  // Start sequencing and done
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      cmd_seen  <= 1'b0;
      start_d1  <= 1'b0;
      start     <= 1'b0;
      ctrl_done <= 1'b0;
    end else begin
      // Two stage delay behind the captured strobe
      cmd_seen  <= ctrl_start;
      start_d1  <= cmd_seen;
      start     <= start_d1;
      // One cycle after the last response
      ctrl_done <= final_bxfer;
    end
  end

endmodule : xfer_ctrl

/* verilog/wdata_fifo.sv */
// Stream data FIFO
`timescale 1ns/1ps

module wdata_fifo
  import axi_bus_pkg::*;
  import write_master_pkg::*;
(
  input  logic              aclk,
  input  logic              areset,
  input  logic              push,
  input  logic [data_w-1:0] push_data,
  input  logic              pop,
  output logic              full,
  output logic              fifo_valid,
  output logic [data_w-1:0] fifo_data
);

  logic [data_w-1:0]   mem [fifo_depth];
  // Extra top bit tells full from empty
  logic [fifo_ptr_w:0] wr_ptr;
  logic [fifo_ptr_w:0] rd_ptr;
  logic                empty;
  logic                do_push;
  logic                do_pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[fifo_ptr_w] != rd_ptr[fifo_ptr_w]) &&
                 (wr_ptr[fifo_ptr_w-1:0] == rd_ptr[fifo_ptr_w-1:0]);

  // Push on full and pop on empty are dropped
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // Storage array
  always_ff @(posedge aclk) begin
    if (do_push)
      mem[wr_ptr[fifo_ptr_w-1:0]] <= push_data;
  end

  // Pointers
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Head word shows without a read request
  assign fifo_valid = ~empty;
  assign fifo_data  = mem[rd_ptr[fifo_ptr_w-1:0]];

endmodule : wdata_fifo

/* verilog/wbeat_sequencer.sv */
// Write data channel
`timescale 1ns/1ps

module wbeat_sequencer
  import axi_bus_pkg::*;
  import write_master_pkg::*;
(
  input  logic                  aclk,
  input  logic                  areset,
  input  logic                  start,
  input  logic [xact_cnt_w-1:0] num_xacts,
  input  logic [len_w-1:0]      final_burst_len,
  input  logic                  single_xact,
  input  logic [strb_w-1:0]     final_strb,
  input  logic                  fifo_valid,
  input  logic [data_w-1:0]     fifo_data,
  input  logic                  m_axi_wready,
  output logic                  fifo_pop,
  output logic                  m_axi_wvalid,
  output logic [data_w-1:0]     m_axi_wdata,
  output logic [strb_w-1:0]     m_axi_wstrb,
  output logic                  m_axi_wlast,
  output logic                  wxfer,
  output logic                  wfirst_pulse
);

  logic                  running;
  logic [len_w-1:0]      beats_to_go;
  logic [xact_cnt_w-1:0] bursts_to_go;
  logic                  final_burst;
  logic                  load_beats;
  logic                  wfirst;
  logic                  wfirst_d1;

  // No beats leave before the transfer size is known
  assign m_axi_wvalid = fifo_valid & running;
  assign m_axi_wdata  = fifo_data;
  assign wxfer        = m_axi_wvalid & m_axi_wready;
  assign fifo_pop     = wxfer;

  assign final_burst = (bursts_to_go == '0);
  assign m_axi_wlast = (beats_to_go == '0);
  assign m_axi_wstrb = (m_axi_wlast & final_burst) ? final_strb : '1;

  // Short burst length comes in for the last burst only
  assign load_beats = (wxfer & m_axi_wlast & (bursts_to_go == xact_cnt_w'(1))) ||
                      (start & single_xact);

  always_ff @(posedge aclk) begin
    if (areset) begin
      running      <= 1'b0;
      beats_to_go  <= '1;
      bursts_to_go <= '0;
      wfirst       <= 1'b1;
      wfirst_d1    <= 1'b0;
      wfirst_pulse <= 1'b0;
    end else begin
      if (start)
        running <= 1'b1;
      else if (wxfer & m_axi_wlast & final_burst)
        running <= 1'b0;
      // Beat counter wraps 0 to 255 between full bursts
      if (load_beats)
        beats_to_go <= final_burst_len;
      else if (wxfer)
        beats_to_go <= beats_to_go - 1'b1;
      if (start)
        bursts_to_go <= num_xacts;
      else if (wxfer & m_axi_wlast)
        bursts_to_go <= bursts_to_go - 1'b1;
      // Next beat opens a burst after WLAST
      if (wxfer)
        wfirst <= m_axi_wlast;
      // One pulse per waiting first beat
      wfirst_d1    <= m_axi_wvalid & wfirst;
      wfirst_pulse <= m_axi_wvalid & wfirst & ~wfirst_d1;
    end
  end

endmodule : wbeat_sequencer

/* verilog/aw_issuer.sv */
// Write address channel
`timescale 1ns/1ps

module aw_issuer
  import axi_bus_pkg::*;
  import write_master_pkg::*;
(
  input  logic                  aclk,
  input  logic                  areset,
  input  logic                  start,
  input  logic [addr_w-1:0]     addr_base,
  input  logic [xact_cnt_w-1:0] num_xacts,
  input  logic [len_w-1:0]      final_burst_len,
  input  logic                  single_xact,
  input  logic                  wfirst_pulse,
  input  logic                  stall_aw,
  input  logic                  m_axi_awready,
  output logic                  m_axi_awvalid,
  output logic [addr_w-1:0]     m_axi_awaddr,
  output logic [len_w-1:0]      m_axi_awlen,
  output logic                  awxfer
);

  logic [pending_w-1:0]  pending;
  logic [xact_cnt_w-1:0] aw_to_go;
  logic                  final_aw;

  assign awxfer   = m_axi_awvalid & m_axi_awready;
  assign final_aw = (aw_to_go == '0);

  // Full bursts get 255, the last one its own length
  assign m_axi_awlen = (final_aw || (start & single_xact)) ? final_burst_len :
                                                             len_w'(burst_beats - 1);

  ////////////////////////////////////////////////////////////
  // Address valid and counters
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      pending       <= '0;
      m_axi_awvalid <= 1'b0;
      aw_to_go      <= '0;
    end else begin
      // First beats seen but not yet addressed
      case ({wfirst_pulse, awxfer})
        2'b10:   pending <= pending + 1'b1;
        2'b01:   pending <= pending - 1'b1;
        default: pending <= pending;
      endcase
      // Held until the slave takes it
      if ((pending != '0) & ~m_axi_awvalid & ~stall_aw)
        m_axi_awvalid <= 1'b1;
      else if (m_axi_awready)
        m_axi_awvalid <= 1'b0;
      if (start)
        aw_to_go <= num_xacts;
      else if (awxfer)
        aw_to_go <= aw_to_go - 1'b1;
    end
  end

  // Next burst sits one full burst higher
  always_ff @(posedge aclk) begin
    if (start)
      m_axi_awaddr <= addr_base;
    else if (awxfer)
      m_axi_awaddr <= m_axi_awaddr + addr_w'(burst_bytes);
  end

endmodule : aw_issuer

/* verilog/bresp_tracker.sv */
// Write response channel
`timescale 1ns/1ps

module bresp_tracker
  import write_master_pkg::*;
(
  input  logic                  aclk,
  input  logic                  areset,
  input  logic                  start,
  input  logic [xact_cnt_w-1:0] num_xacts,
  input  logic                  awxfer,
  input  logic                  m_axi_bvalid,
  output logic                  m_axi_bready,
  output logic                  stall_aw,
  output logic                  final_bxfer
);

  logic                     bxfer;
  logic [outstanding_w-1:0] vacancy;
  logic [xact_cnt_w-1:0]    b_to_go;

  // Responses are always accepted
  assign m_axi_bready = 1'b1;
  assign bxfer        = m_axi_bvalid & m_axi_bready;

  // No free slot for another burst
  assign stall_aw    = (vacancy == '0);
  assign final_bxfer = bxfer & (b_to_go == '0);

  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy <= outstanding_w'(max_outstanding);
      b_to_go <= '0;
    end else begin
      case ({awxfer, bxfer})
        2'b10:   vacancy <= vacancy - 1'b1;
        2'b01:   vacancy <= vacancy + 1'b1;
        default: vacancy <= vacancy;
      endcase
      if (start)
        b_to_go <= num_xacts;
      else if (bxfer)
        b_to_go <= b_to_go - 1'b1;
    end
  end

endmodule : bresp_tracker

/* verilog/axi_write_master.sv */
// AXI4 write master
// Stream in, bursts out
`timescale 1ns/1ps

module axi_write_master
  import axi_bus_pkg::*;
  import write_master_pkg::*;
(
  input  logic                   aclk,
  input  logic                   areset,
  // Command
  input  logic                   ctrl_start,
  input  logic [addr_w-1:0]      ctrl_addr_offset,
  input  logic [xfer_size_w-1:0] ctrl_xfer_size_in_bytes,
  output logic                   ctrl_done,
  // Stream input
  input  logic                   s_axis_tvalid,
  output logic                   s_axis_tready,
  input  logic [data_w-1:0]      s_axis_tdata,
  // Write address
  output logic                   m_axi_awvalid,
  input  logic                   m_axi_awready,
  output logic [addr_w-1:0]      m_axi_awaddr,
  output logic [len_w-1:0]       m_axi_awlen,
  // Write data
  output logic                   m_axi_wvalid,
  input  logic                   m_axi_wready,
  output logic [data_w-1:0]      m_axi_wdata,
  output logic [strb_w-1:0]      m_axi_wstrb,
  output logic                   m_axi_wlast,
  // Write response
  input  logic                   m_axi_bvalid,
  output logic                   m_axi_bready
);

  logic                  start;
  logic [xact_cnt_w-1:0] num_xacts;
  logic [len_w-1:0]      final_burst_len;
  logic                  single_xact;
  logic [strb_w-1:0]     final_strb;
  logic [addr_w-1:0]     addr_base;
  logic                  wfirst_pulse;
  logic                  awxfer;
  logic                  stall_aw;
  logic                  final_bxfer;
  logic                  fifo_full;
  logic                  fifo_valid;
  logic [data_w-1:0]     fifo_data;
  logic                  fifo_pop;

  // Stream stalls only on a full buffer
  assign s_axis_tready = ~fifo_full;

  xfer_ctrl i_xfer_ctrl (
    .aclk, .areset, .ctrl_start, .ctrl_addr_offset, .ctrl_xfer_size_in_bytes,
    .final_bxfer, .start, .num_xacts, .final_burst_len, .single_xact,
    .final_strb, .addr_base, .ctrl_done
  );

  wdata_fifo i_wdata_fifo (
    .aclk, .areset, .push(s_axis_tvalid), .push_data(s_axis_tdata),
    .pop(fifo_pop), .full(fifo_full), .fifo_valid, .fifo_data
  );

  wbeat_sequencer i_wbeat_sequencer (
    .aclk, .areset, .start, .num_xacts, .final_burst_len, .single_xact,
    .final_strb, .fifo_valid, .fifo_data, .m_axi_wready, .fifo_pop,
    .m_axi_wvalid, .m_axi_wdata, .m_axi_wstrb, .m_axi_wlast, .wxfer(), .wfirst_pulse
  );

  aw_issuer i_aw_issuer (
    .aclk, .areset, .start, .addr_base, .num_xacts, .final_burst_len,
    .single_xact, .wfirst_pulse, .stall_aw, .m_axi_awready, .m_axi_awvalid,
    .m_axi_awaddr, .m_axi_awlen, .awxfer
  );

  bresp_tracker i_bresp_tracker (
    .aclk, .areset, .start, .num_xacts, .awxfer, .m_axi_bvalid,
    .m_axi_bready, .stall_aw, .final_bxfer
  );

endmodule : axi_write_master

/* dv/axi_write_master_assertions.sv */
// AXI write master checker
`timescale 1ns/1ps

module axi_write_master_assertions
  import axi_bus_pkg::*;
  import write_master_pkg::*;
(
  input logic                   aclk,
  input logic                   areset,
  input logic                   ctrl_start,
  input logic [addr_w-1:0]      ctrl_addr_offset,
  input logic [xfer_size_w-1:0] ctrl_xfer_size_in_bytes,
  input logic                   ctrl_done,
  input logic                   s_axis_tvalid,
  input logic                   s_axis_tready,
  input logic [data_w-1:0]      s_axis_tdata,
  input logic                   m_axi_awvalid,
  input logic                   m_axi_awready,
  input logic [addr_w-1:0]      m_axi_awaddr,
  input logic [len_w-1:0]       m_axi_awlen,
  input logic                   m_axi_wvalid,
  input logic                   m_axi_wready,
  input logic [data_w-1:0]      m_axi_wdata,
  input logic [strb_w-1:0]      m_axi_wstrb,
  input logic                   m_axi_wlast,
  input logic                   m_axi_bvalid,
  input logic                   m_axi_bready
);

  logic [addr_w-1:0] exp_base;
  logic [1:0]        byte_rem;
  int                n_beats;
  int                n_bursts;
  int                aw_idx;
  int                w_idx;
  int                beat_idx;
  int                b_idx;
  int                outstanding;
  int                cur_len;
  logic [data_w-1:0] word_log [64];
  logic [5:0]        word_wr;
  logic [5:0]        word_rd;
  logic              done_due;
  logic              awxfer;
  logic              wxfer;
  logic              bxfer;
  logic              last_burst;
  logic [strb_w-1:0] last_strb;

  assign awxfer = m_axi_awvalid & m_axi_awready;
  assign wxfer  = m_axi_wvalid & m_axi_wready;
  assign bxfer  = m_axi_bvalid & m_axi_bready;

  // Last burst runs (beats - 1) mod 256, every other one 256 beats
  assign last_burst = (w_idx == n_bursts - 1);
  assign cur_len    = last_burst ? (n_beats - 1) % 256 : 255;
  // Lowest remainder bytes, or the whole word on an even byte count
  assign last_strb  = (byte_rem == 2'd0) ? 4'hf : 4'((1 << byte_rem) - 1);

  ////////////////////////////////////////////////////////////
  // Reference tallies
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      n_bursts    <= 0;
      aw_idx      <= 0;
      w_idx       <= 0;
      beat_idx    <= 0;
      b_idx       <= 0;
      outstanding <= 0;
      word_wr     <= '0;
      word_rd     <= '0;
      done_due    <= 1'b0;
    end else begin
      if (ctrl_start) begin
        exp_base <= {ctrl_addr_offset[addr_w-1:10], 10'b0};
        byte_rem <= ctrl_xfer_size_in_bytes[1:0];
        n_beats  <= (int'(ctrl_xfer_size_in_bytes) + 3) / 4;
        // Whole 1 KB bursts, rounded up
        n_bursts <= (int'(ctrl_xfer_size_in_bytes) + 1023) / 1024;
        aw_idx   <= 0;
        w_idx    <= 0;
        beat_idx <= 0;
        b_idx    <= 0;
      end else begin
        if (awxfer)
          aw_idx <= aw_idx + 1;
        if (wxfer && m_axi_wlast) begin
          beat_idx <= 0;
          w_idx    <= w_idx + 1;
        end else if (wxfer)
          beat_idx <= beat_idx + 1;
        if (bxfer)
          b_idx <= b_idx + 1;
      end
      outstanding <= outstanding + int'(awxfer) - int'(bxfer);
      // Stream words in arrival order
      if (s_axis_tvalid && s_axis_tready) begin
        word_log[word_wr] <= s_axis_tdata;
        word_wr           <= word_wr + 1'b1;
      end
      if (wxfer)
        word_rd <= word_rd + 1'b1;
      done_due <= bxfer && (b_idx == n_bursts - 1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  addr_check: assert property (@(posedge aclk) disable iff (areset)
    awxfer |-> m_axi_awaddr == exp_base + addr_w'(aw_idx * 1024))
    else $error("MISMATCH at %0t: awaddr wrong for burst %0d", $time, aw_idx);

  len_check: assert property (@(posedge aclk) disable iff (areset)
    awxfer |-> aw_idx < n_bursts && m_axi_awlen ==
      len_w'((aw_idx == n_bursts - 1) ? (n_beats - 1) % 256 : 255))
    else $error("MISMATCH at %0t: awlen wrong or extra burst %0d", $time, aw_idx);

  wlast_check: assert property (@(posedge aclk) disable iff (areset)
    wxfer |-> w_idx < n_bursts && m_axi_wlast == (beat_idx == cur_len))
    else $error("MISMATCH at %0t: wlast wrong at beat %0d", $time, beat_idx);

  wstrb_check: assert property (@(posedge aclk) disable iff (areset)
    wxfer |-> m_axi_wstrb == ((last_burst && beat_idx == cur_len) ? last_strb : 4'hf))
    else $error("MISMATCH at %0t: wstrb %h", $time, m_axi_wstrb);

  order_check: assert property (@(posedge aclk) disable iff (areset)
    wxfer |-> m_axi_wdata == word_log[word_rd])
    else $error("MISMATCH at %0t: wdata out of stream order", $time);

  // Response limit and address stall
  limit_check: assert property (@(posedge aclk) disable iff (areset)
    outstanding <= max_outstanding)
    else $error("more than four bursts awaiting a response at %0t", $time);

  stall_check: assert property (@(posedge aclk) disable iff (areset)
    outstanding == max_outstanding |-> !m_axi_awvalid)
    else $error("awvalid raised with four bursts outstanding at %0t", $time);

  // Done exactly one cycle after the final response
  done_check: assert property (@(posedge aclk) disable iff (areset)
    ctrl_done == done_due)
    else $error("MISMATCH at %0t: ctrl_done pulse misplaced", $time);

  count_check: assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |-> aw_idx == n_bursts && w_idx == n_bursts)
    else $error("MISMATCH at %0t: burst count at done", $time);

endmodule : axi_write_master_assertions

bind axi_write_master axi_write_master_assertions i_axi_write_master_assertions (.*);

/* dv/tb_axi_write_master.sv */
// AXI write master testbench
`timescale 1ns/1ps

module tb_axi_write_master
  import axi_bus_pkg::*;
  import write_master_pkg::*;
();

  logic                   aclk = 1'b0;
  logic                   areset = 1'b1;
  logic                   ctrl_start = 1'b0;
  logic [addr_w-1:0]      ctrl_addr_offset = '0;
  logic [xfer_size_w-1:0] ctrl_xfer_size_in_bytes = '0;
  logic                   ctrl_done;
  logic                   s_axis_tvalid = 1'b0;
  logic                   s_axis_tready;
  logic [data_w-1:0]      s_axis_tdata = '0;
  logic                   m_axi_awvalid;
  logic                   m_axi_awready = 1'b0;
  logic [addr_w-1:0]      m_axi_awaddr;
  logic [len_w-1:0]       m_axi_awlen;
  logic                   m_axi_wvalid;
  logic                   m_axi_wready = 1'b0;
  logic [data_w-1:0]      m_axi_wdata;
  logic [strb_w-1:0]      m_axi_wstrb;
  logic                   m_axi_wlast;
  logic                   m_axi_bvalid = 1'b0;
  logic                   m_axi_bready;

  // Slave and stream knobs, in percent
  int                wready_pct = 100;
  int                awready_pct = 100;
  int                gap_pct = 0;
  bit                hold_resp = 1'b0;
  int                words_queued = 0;
  int                words_sent = 0;
  logic [addr_w-1:0] aw_q [$];
  int                wlast_pend = 0;
  int                resp_count = 0;
  int                pass_count = 0;
  int                fail_count = 0;
  bit                aborted = 1'b0;

  always #20 aclk = ~aclk;

  axi_write_master i_axi_write_master (.*);

  ////////////////////////////////////////////////////////////
  // Stream source
  ////////////////////////////////////////////////////////////
  always @(posedge aclk) begin
    if (areset) begin
      s_axis_tvalid <= 1'b0;
    end else begin
      if (s_axis_tvalid && s_axis_tready)
        words_sent = words_sent + 1;
      // Offered word stays until taken
      if (!s_axis_tvalid || s_axis_tready) begin
        if (words_sent < words_queued && ($urandom % 100) >= gap_pct) begin
          s_axis_tvalid <= 1'b1;
          s_axis_tdata  <= 32'h5a00_0000 + data_w'(words_sent);
        end else
          s_axis_tvalid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Slave model
  ////////////////////////////////////////////////////////////
  always @(posedge aclk) begin
    if (areset) begin
      m_axi_awready <= 1'b0;
      m_axi_wready  <= 1'b0;
      m_axi_bvalid  <= 1'b0;
    end else begin
      if (m_axi_bvalid && m_axi_bready) begin
        void'(aw_q.pop_front());
        wlast_pend = wlast_pend - 1;
        resp_count = resp_count + 1;
      end
      if (m_axi_awvalid && m_axi_awready)
        aw_q.push_back(m_axi_awaddr);
      if (m_axi_wvalid && m_axi_wready && m_axi_wlast)
        wlast_pend = wlast_pend + 1;
      // Answer once the address and the last beat are both in
      m_axi_bvalid  <= (aw_q.size() > 0) && (wlast_pend > 0) && !hold_resp;
      m_axi_awready <= ($urandom % 100) < awready_pct;
      m_axi_wready  <= ($urandom % 100) < wready_pct;
    end
  end

  // One command, then wait for ctrl_done
  task automatic run_transfer(input string name, input logic [addr_w-1:0] addr,
                              input int bytes, input int w_pct, input int aw_pct,
                              input int g_pct, input bit hold);
    int beats;
    int bursts;
    int resp_before;
    int cycles;
    int limit;
    beats  = (bytes + 3) / 4;
    bursts = (bytes + 1023) / 1024;
    limit  = 500 + 40 * beats;
    if (aborted)
      return;
    @(posedge aclk);
    wready_pct              <= w_pct;
    awready_pct             <= aw_pct;
    gap_pct                 <= g_pct;
    hold_resp               <= hold;
    words_queued            <= words_queued + beats;
    ctrl_start              <= 1'b1;
    ctrl_addr_offset        <= addr;
    ctrl_xfer_size_in_bytes <= xfer_size_w'(bytes);
    @(posedge aclk);
    ctrl_start  <= 1'b0;
    resp_before = resp_count;
    cycles      = 0;
    if (hold) begin
      // Four bursts pile up, then wait a while with no response
      while (aw_q.size() < max_outstanding && cycles < limit) begin
        @(posedge aclk);
        cycles++;
      end
      if (aw_q.size() < max_outstanding) begin
        $display("test %s: four bursts never came up for a response", name);
        fail_count++;
        aborted = 1'b1;
        return;
      end
      repeat (64) @(posedge aclk);
      hold_resp <= 1'b0;
      cycles = 0;
    end
    while (!ctrl_done && cycles < limit) begin
      @(posedge aclk);
      cycles++;
    end
    if (!ctrl_done) begin
      $display("test %s: timed out after %0d cycles waiting for ctrl_done", name, limit);
      fail_count++;
      aborted = 1'b1;
    end else if (resp_count - resp_before != bursts) begin
      $display("MISMATCH at %0t: test %s took %0d responses, expected %0d", $time, name,
               resp_count - resp_before, bursts);
      fail_count++;
    end else begin
      $display("test %s: %0d bytes in %0d bursts done", name, bytes, bursts);
      pass_count++;
    end
  endtask

  initial begin
    int i;
    void'($urandom(43));
    repeat (8) @(posedge aclk);
    areset <= 1'b0;
    repeat (2) @(posedge aclk);
    // Short, odd and exact sizes
    run_transfer("single_short", 32'h0000_1234, 37, 100, 100, 0, 1'b0);
    run_transfer("three_bursts", 32'h0002_07fc, 2050, 70, 60, 10, 1'b0);
    run_transfer("one_full_burst", 32'h0000_0010, 1024, 80, 50, 20, 1'b0);
    // Slow wready fills the FIFO while the stream has gaps
    run_transfer("stalled_stream", 32'h0010_0a00, 3003, 25, 50, 30, 1'b0);
    run_transfer("resp_holdoff", 32'h0040_0000, 6000, 90, 80, 5, 1'b1);
    for (i = 0; i < 4; i++) begin
      run_transfer($sformatf("random_%0d", i), $urandom, 1 + int'($urandom % 5000),
                   30 + int'($urandom % 70), 30 + int'($urandom % 70),
                   int'($urandom % 50), 1'b0);
    end
    $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule : tb_axi_write_master

/* compile.f */
verilog/axi_bus_pkg.sv
verilog/write_master_pkg.sv
verilog/xfer_ctrl.sv
verilog/wdata_fifo.sv
verilog/wbeat_sequencer.sv
verilog/aw_issuer.sv
verilog/bresp_tracker.sv
verilog/axi_write_master.sv
dv/axi_write_master_assertions.sv
dv/tb_axi_write_master.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the AXI write master testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_write_master -f compile.f
out=$(./obj_dir/Vtb_axi_write_master 2>&1 || true)
echo "$out"
if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
